// File: Bender.yml
package:
  name: dataframe

sources:
  - files:
      - hdl/dataframe_pkg.sv
      - hdl/sync_fifo.sv
      - hdl/frame_request_gate.sv
      - hdl/dataframe_gen.sv
      - hdl/dataframe_top.sv
  - target: test
    files:
      - tb/dataframe_checker.sv
      - tb/tb_dataframe_top.sv

// File: compile.f
hdl/dataframe_pkg.sv
hdl/sync_fifo.sv
hdl/frame_request_gate.sv
hdl/dataframe_gen.sv
hdl/dataframe_top.sv
tb/dataframe_checker.sv
tb/tb_dataframe_top.sv

// File: hdl/dataframe_gen.sv
`timescale 1ns/100ps
`default_nettype none

module dataframe_gen
    import dataframe_pkg::*;
(
    input  wire                    ACLK,
    input  wire                    arst_n,

    input  wire                    hf_empty,
    input  wire hf_record_u        hf_dout,
    output logic                   hf_rd_en,

    input  wire                    smp_empty,
    input  wire [TDATA_WIDTH-1:0]  smp_dout,
    output logic                   smp_rd_en,

    input  wire                    m_axis_tready,
    output axis_beat_t             m_axis,

    output logic                   underflow
);

    // One extra bit so header plus frame length plus footer always fits
    localparam int CNT_W = FLEN_WIDTH + 1;

    logic [CNT_W-1:0]       beat_idx;
    logic [CNT_W-1:0]       data_end;
    logic                   in_header;
    logic                   in_data;
    logic                   load_ok;
    logic                   step;
    logic                   take_sample;
    logic                   take_footer;
    logic                   starve;

    logic [TDATA_WIDTH-1:0] out_data;
    logic                   out_valid;
    logic                   out_last;

    // Header and footer lines go out with the upper half all ones
    function automatic logic [TDATA_WIDTH-1:0] line_beat(input logic [LINE_WIDTH-1:0] line);
        return {{(TDATA_WIDTH - LINE_WIDTH){1'b1}}, line};
    endfunction

    // The record stays at the FIFO head for the whole frame
    assign data_end  = CNT_W'(HEADER_LINES) + CNT_W'(hf_dout.field.frame_len);
    assign in_header = (beat_idx < CNT_W'(HEADER_LINES));
    assign in_data   = !in_header && (beat_idx < data_end);

    // The output register takes a new beat when empty or when its beat leaves
    assign load_ok = !out_valid || m_axis_tready;
    assign step    = load_ok && !hf_empty;

    assign take_sample = step && in_data && !smp_empty;
    assign starve      = step && in_data && smp_empty;
    assign take_footer = step && !in_header && !in_data;

    // A starved frame is dropped along with its record
    assign hf_rd_en  = take_footer || starve;
    assign smp_rd_en = take_sample;

    always_ff @(posedge ACLK or negedge arst_n) begin
        if (!arst_n) begin
            beat_idx  <= '0;
            out_valid <= 1'b0;
            out_last  <= 1'b0;
            underflow <= 1'b0;
        end else begin
            if (load_ok) begin
                out_valid <= step && !starve;
                out_last  <= take_footer;
            end

            if (take_footer || starve) begin
                beat_idx <= '0;
            end else if (step) begin
                beat_idx <= beat_idx + 1'b1;
            end

            if (starve) begin
                underflow <= 1'b1;
            end
        end
    end

    always_ff @(posedge ACLK) begin
        if (step && !starve) begin
            if (in_header) begin
                out_data <= line_beat(hf_dout.line[beat_idx[1:0]]);
            end else if (in_data) begin
                out_data <= smp_dout;
            end else begin
                out_data <= line_beat(hf_dout.line[HEADER_LINES]);
            end
        end
    end

    assign m_axis.tdata  = out_data;
    assign m_axis.tvalid = out_valid;
    assign m_axis.tlast  = out_last;

endmodule

`default_nettype wire

// File: hdl/dataframe_pkg.sv
`default_nettype none

package dataframe_pkg;

    // Header and footer lines are 16 bits, the stream carries 32-bit samples
    localparam int LINE_WIDTH   = 16;
    localparam int TDATA_WIDTH  = 32;
    localparam int HEADER_LINES = 3;
    localparam int FOOTER_LINES = 1;
    localparam int FLEN_WIDTH   = 12;

    localparam int CH_WIDTH       = 4;
    localparam int SEQ_WIDTH      = 16;
    localparam int TAG_WIDTH      = 4;
    localparam int FOOT_SEQ_WIDTH = 8;

    localparam int HF_WIDTH = (HEADER_LINES + FOOTER_LINES) * LINE_WIDTH;

    localparam logic [LINE_WIDTH-1:0] SYNC_WORD  = 16'hA5A5;
    localparam logic [TAG_WIDTH-1:0]  FOOTER_TAG = 4'hF;

    // Line 0 sits in the most significant bits, the footer line in the least
    typedef logic [0:HEADER_LINES+FOOTER_LINES-1][LINE_WIDTH-1:0] hf_lines_t;

    typedef struct packed {
        logic [LINE_WIDTH-1:0]     sync;
        logic [CH_WIDTH-1:0]       ch_id;
        logic [FLEN_WIDTH-1:0]     frame_len;
        logic [SEQ_WIDTH-1:0]      seq;
        logic [TAG_WIDTH-1:0]      foot_tag;
        logic [CH_WIDTH-1:0]       foot_ch;
        logic [FOOT_SEQ_WIDTH-1:0] foot_seq;
    } hf_fields_t;

    // The producer fills in named fields, the assembler walks the lines
    typedef union packed {
        hf_lines_t  line;
        hf_fields_t field;
    } hf_record_u;

    typedef struct packed {
        logic [TDATA_WIDTH-1:0] tdata;
        logic                   tvalid;
        logic                   tlast;
    } axis_beat_t;

    typedef struct packed {
        logic                  valid;
        logic [CH_WIDTH-1:0]   ch_id;
        logic [FLEN_WIDTH-1:0] frame_len;
    } frame_req_t;

    // All three flags are sticky until reset
    typedef struct packed {
        logic underflow;
        logic req_dropped;
        logic sample_dropped;
    } frame_status_t;

endpackage

`default_nettype wire

// File: hdl/dataframe_top.sv
`timescale 1ns/100ps
`default_nettype none

module dataframe_top
    import dataframe_pkg::*;
#(
    parameter int FIFO_DEPTH    = 64,
    parameter int HF_DEPTH      = 4,
    parameter int MAX_FRAME_LEN = 48
) (
    input  wire                   ACLK,
    input  wire                   arst_n,

    input  wire frame_req_t       req,

    input  wire                   sample_valid,
    input  wire [TDATA_WIDTH-1:0] sample_data,

    input  wire                   m_axis_tready,
    output axis_beat_t            m_axis,

    output frame_status_t         status
);

    logic                   hf_wr_en;
    hf_record_u             hf_wr_data;
    logic                   hf_full;
    logic                   hf_empty;
    hf_record_u             hf_dout;
    logic                   hf_rd_en;

    logic                   smp_empty;
    logic [TDATA_WIDTH-1:0] smp_dout;
    logic                   smp_rd_en;
    logic                   smp_overflow;

    logic                   underflow;
    logic                   req_dropped;

    frame_request_gate #(
        .MAX_FRAME_LEN (MAX_FRAME_LEN)
    ) u_req_gate (
        .ACLK        (ACLK),
        .arst_n      (arst_n),
        .req         (req),
        .hf_full     (hf_full),
        .hf_wr_en    (hf_wr_en),
        .hf_wr_data  (hf_wr_data),
        .req_dropped (req_dropped)
    );

    // The gate checks full before writing, so this overflow stays unused
    sync_fifo #(
        .WIDTH (HF_WIDTH),
        .DEPTH (HF_DEPTH)
    ) u_hf_fifo (
        .ACLK     (ACLK),
        .arst_n   (arst_n),
        .wr_en    (hf_wr_en),
        .wr_data  (hf_wr_data),
        .rd_en    (hf_rd_en),
        .rd_data  (hf_dout),
        .empty    (hf_empty),
        .full     (hf_full),
        .overflow ()
    );

    sync_fifo #(
        .WIDTH (TDATA_WIDTH),
        .DEPTH (FIFO_DEPTH)
    ) u_smp_fifo (
        .ACLK     (ACLK),
        .arst_n   (arst_n),
        .wr_en    (sample_valid),
        .wr_data  (sample_data),
        .rd_en    (smp_rd_en),
        .rd_data  (smp_dout),
        .empty    (smp_empty),
        .full     (),
        .overflow (smp_overflow)
    );

    dataframe_gen u_gen (
        .ACLK          (ACLK),
        .arst_n        (arst_n),
        .hf_empty      (hf_empty),
        .hf_dout       (hf_dout),
        .hf_rd_en      (hf_rd_en),
        .smp_empty     (smp_empty),
        .smp_dout      (smp_dout),
        .smp_rd_en     (smp_rd_en),
        .m_axis_tready (m_axis_tready),
        .m_axis        (m_axis),
        .underflow     (underflow)
    );

    // Each flag stays set until reset
    assign status.underflow      = underflow;
    assign status.req_dropped    = req_dropped;
    assign status.sample_dropped = smp_overflow;

endmodule

`default_nettype wire

// File: hdl/frame_request_gate.sv
`timescale 1ns/100ps
`default_nettype none

module frame_request_gate
    import dataframe_pkg::*;
#(
    parameter int MAX_FRAME_LEN = 48
) (
    input  wire             ACLK,
    input  wire             arst_n,

    input  wire frame_req_t req,

    input  wire             hf_full,
    output logic            hf_wr_en,
    output hf_record_u      hf_wr_data,

    output logic            req_dropped
);

    localparam logic [FLEN_WIDTH-1:0] MAX_LEN = FLEN_WIDTH'(MAX_FRAME_LEN);

    logic                 len_ok;
    logic                 accept;
    logic [SEQ_WIDTH-1:0] seq_cnt;

    // A zero length or anything above the limit is not a frame at all
    assign len_ok = (req.frame_len != '0) && (req.frame_len <= MAX_LEN);

    assign accept = req.valid && len_ok && !hf_full;

    // The record is written into the header FIFO on the edge that ends
    // the request cycle, so the FIFO never sees a write while full
    assign hf_wr_en = accept;

    always_comb begin
        hf_wr_data.field.sync      = SYNC_WORD;
        hf_wr_data.field.ch_id     = req.ch_id;
        hf_wr_data.field.frame_len = req.frame_len;
        hf_wr_data.field.seq       = seq_cnt;
        hf_wr_data.field.foot_tag  = FOOTER_TAG;
        hf_wr_data.field.foot_ch   = req.ch_id;
        hf_wr_data.field.foot_seq  = seq_cnt[FOOT_SEQ_WIDTH-1:0];
    end

    // Only accepted frames consume a sequence number
    always_ff @(posedge ACLK or negedge arst_n) begin
        if (!arst_n) begin
            seq_cnt <= '0;
        end else if (accept) begin
            seq_cnt <= seq_cnt + 1'b1;
        end
    end

    // Well-formed requests that find the FIFO full are lost
    always_ff @(posedge ACLK or negedge arst_n) begin
        if (!arst_n) begin
            req_dropped <= 1'b0;
        end else if (req.valid && len_ok && hf_full) begin
            req_dropped <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: hdl/sync_fifo.sv
`timescale 1ns/100ps
`default_nettype none

module sync_fifo #(
    parameter int WIDTH = 32,
    parameter int DEPTH = 64
) (
    input  wire              ACLK,
    input  wire              arst_n,

    input  wire              wr_en,
    input  wire  [WIDTH-1:0] wr_data,

    input  wire              rd_en,
    output logic [WIDTH-1:0] rd_data,

    output logic             empty,
    output logic             full,
    output logic             overflow
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_wr;
    logic             do_rd;

    // Pointers wrap explicitly so the depth need not be a power of two
    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign empty = (count == '0);
    assign full  = (count == CNT_W'(DEPTH));

    assign do_wr = wr_en && !full;
    assign do_rd = rd_en && !empty;

    // Head word is visible without a read cycle
    assign rd_data = mem[rd_ptr];

    always_ff @(posedge ACLK) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    always_ff @(posedge ACLK or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            overflow <= 1'b0;
        end else begin
            if (do_wr) begin
                wr_ptr <= ptr_next(wr_ptr);
            end
            if (do_rd) begin
                rd_ptr <= ptr_next(rd_ptr);
            end
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            if (wr_en && full) begin
                overflow <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: tb/dataframe_checker.sv
`timescale 1ns/100ps
`default_nettype none

module dataframe_checker
    import dataframe_pkg::*;
(
    input wire             ACLK,
    input wire             arst_n,
    input wire axis_beat_t m_axis,
    input wire             m_axis_tready,
    input wire             underflow
);

    // A stalled beat keeps its data and its last flag until it transfers
    property beat_holds_while_stalled;
        @(posedge ACLK) disable iff (!arst_n)
        (m_axis.tvalid && !m_axis_tready) |=>
            (m_axis.tvalid && $stable(m_axis.tdata) && $stable(m_axis.tlast));
    endproperty

    property quiet_in_reset;
        @(posedge ACLK) !arst_n |-> (!m_axis.tvalid && !m_axis.tlast);
    endproperty

    // Underflow is sticky
    property underflow_sticky;
        @(posedge ACLK) disable iff (!arst_n)
        underflow |=> underflow;
    endproperty

    a_beat_hold: assert property (beat_holds_while_stalled)
        else $error("AXI-Stream beat changed while TREADY was low");

    a_reset_quiet: assert property (quiet_in_reset)
        else $error("tvalid or tlast seen during reset");

    a_underflow_sticky: assert property (underflow_sticky)
        else $error("underflow flag fell without a reset");

endmodule

bind dataframe_gen dataframe_checker u_checker (
    .ACLK          (ACLK),
    .arst_n        (arst_n),
    .m_axis        (m_axis),
    .m_axis_tready (m_axis_tready),
    .underflow     (underflow)
);

`default_nettype wire

// File: tb/tb_dataframe_top.sv
`timescale 1ns/100ps
`default_nettype none

module tb_dataframe_top
    import dataframe_pkg::*;
;

    localparam logic [31:0] SEED = 32'hea54a16c;

    // Upper bound of transfers over all six tests
    localparam int MAX_TRANSFERS  = 12 + 6 * 52 + 9 + 4 * 8 + 52 + 20 + 7 + 10;
    localparam int TIMEOUT_CYCLES = MAX_TRANSFERS * 4 + 2000;

    typedef struct packed {
        logic [3:0]  ch;
        logic [11:0] len;
        logic [15:0] seq;
    } frame_t;

    logic          ACLK;
    logic          arst_n;
    frame_req_t    req;
    logic          sample_valid;
    logic [31:0]   sample_data;
    logic          m_axis_tready;
    axis_beat_t    m_axis;
    frame_status_t status;

    logic [31:0]   rnd_state;
    logic [31:0]   ready_state;
    int            ready_mode;
    logic [31:0]   smp_model[$];
    axis_beat_t    exp_q[$];
    int            seq_model;
    int            errors;
    int            beats_checked;
    int            frames_queued;
    int            cycle_count;
    string         test_name;

    dataframe_top DUT (
        .ACLK          (ACLK),
        .arst_n        (arst_n),
        .req           (req),
        .sample_valid  (sample_valid),
        .sample_data   (sample_data),
        .m_axis_tready (m_axis_tready),
        .m_axis        (m_axis),
        .status        (status)
    );

    always #10 ACLK = ~ACLK;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Beat idx of a frame: three header lines, the samples, then the footer
    function automatic axis_beat_t expected_beat(input frame_t f, input int idx,
                                                 input logic [31:0] fs[$]);
        axis_beat_t b;
        b.tvalid = 1'b1;
        b.tlast  = 1'b0;
        if (idx == 0) begin
            b.tdata = {16'hFFFF, SYNC_WORD};
        end else if (idx == 1) begin
            b.tdata = {16'hFFFF, f.ch, f.len};
        end else if (idx == 2) begin
            b.tdata = {16'hFFFF, f.seq};
        end else if (idx < 3 + int'(f.len)) begin
            b.tdata = fs[idx-3];
        end else begin
            b.tdata = {16'hFFFF, FOOTER_TAG, f.ch, f.seq[7:0]};
            b.tlast = 1'b1;
        end
        return b;
    endfunction

    // A frame with fewer samples than its length is cut after the last one
    task automatic queue_frame(input logic [3:0] ch, input int len, input int avail);
        frame_t      f;
        logic [31:0] fs[$];
        int          n_beats;
        f.ch  = ch;
        f.len = 12'(len);
        f.seq = 16'(seq_model);
        seq_model++;
        for (int i = 0; i < avail; i++) begin
            fs.push_back(smp_model.pop_front());
        end
        n_beats = (avail < len) ? 3 + avail : len + 4;
        for (int i = 0; i < n_beats; i++) begin
            exp_q.push_back(expected_beat(f, i, fs));
        end
        frames_queued++;
    endtask

    task automatic push_samples(input int count, input int keep);
        logic [31:0] v;
        for (int i = 0; i < count; i++) begin
            rnd_state = xorshift32(rnd_state);
            v = rnd_state;
            @(posedge ACLK);
            sample_valid <= 1'b1;
            sample_data  <= v;
            if (i < keep) begin
                smp_model.push_back(v);
            end
        end
        @(posedge ACLK);
        sample_valid <= 1'b0;
    endtask

    task automatic send_request(input logic [3:0] ch, input int len);
        @(posedge ACLK);
        req.valid     <= 1'b1;
        req.ch_id     <= ch;
        req.frame_len <= 12'(len);
        @(posedge ACLK);
        req.valid <= 1'b0;
    endtask

    task automatic wait_drain(input int limit);
        int n;
        n = 0;
        while (exp_q.size() != 0 && n < limit) begin
            @(posedge ACLK);
            n++;
        end
        if (exp_q.size() != 0) begin
            errors++;
            $display("ERROR %s: %0d expected beats never came out", test_name, exp_q.size());
            exp_q.delete();
        end
        repeat (4) @(posedge ACLK);
    endtask

    task automatic check_flag(input string what, input logic expected, input logic actual);
        if (actual !== expected) begin
            errors++;
            $display("FAIL %s %s: expected %0b, actual %0b", test_name, what, expected, actual);
        end
    endtask

    // 0 holds TREADY low, 1 holds it high, 2 makes it random
    always @(posedge ACLK) begin
        ready_state = xorshift32(ready_state);
        case (ready_mode)
            0:       m_axis_tready <= 1'b0;
            1:       m_axis_tready <= 1'b1;
            default: m_axis_tready <= (ready_state[1:0] != 2'b00);
        endcase
    end

    always @(posedge ACLK) begin : compare_beats
        axis_beat_t want;
        if (arst_n && m_axis.tvalid && m_axis_tready) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("ERROR %s: unexpected beat 0x%08h on the output", test_name,
                         m_axis.tdata);
            end else begin
                want = exp_q.pop_front();
                beats_checked++;
                if (m_axis.tdata !== want.tdata || m_axis.tlast !== want.tlast) begin
                    errors++;
                    $display("FAIL %s: expected 0x%08h last %0b, actual 0x%08h last %0b",
                             test_name, want.tdata, want.tlast, m_axis.tdata, m_axis.tlast);
                end
            end
        end
    end

    always @(posedge ACLK) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            errors++;
            $display("Timeout after %0d cycles in %s, %0d beats outstanding", cycle_count,
                     test_name, exp_q.size());
            $display("Errors: %0d, beats checked: %0d, frames: %0d", errors, beats_checked,
                     frames_queued);
            $display("Done: errors found");
            $finish;
        end
    end

    initial begin
        int          len;
        logic [3:0]  ch;
        ACLK          = 1'b0;
        arst_n        = 1'b0;
        req           = '0;
        sample_valid  = 1'b0;
        sample_data   = '0;
        m_axis_tready = 1'b0;
        rnd_state     = SEED;
        ready_state   = ~SEED;
        ready_mode    = 1;
        seq_model     = 0;
        errors        = 0;
        beats_checked = 0;
        frames_queued = 0;
        cycle_count   = 0;
        test_name     = "reset";
        repeat (16) @(posedge ACLK);
        arst_n <= 1'b1;
        repeat (2) @(posedge ACLK);

        test_name = "basic_frame";
        push_samples(8, 8);
        queue_frame(4'd3, 8, 8);
        send_request(4'd3, 8);
        wait_drain(200);

        test_name = "random_backpressure";
        ready_mode <= 2;
        for (int f = 0; f < 6; f++) begin
            rnd_state = xorshift32(rnd_state);
            len = int'(rnd_state % 32'd48) + 1;
            ch  = rnd_state[11:8];
            // Keeps the sample FIFO below its depth while the last frame drains
            while (exp_q.size() > 16) begin
                @(posedge ACLK);
            end
            push_samples(len, len);
            queue_frame(ch, len, len);
            send_request(ch, len);
        end
        wait_drain(1500);
        check_flag("status", 1'b0, |status);

        test_name = "length_filter";
        send_request(4'd1, 0);
        send_request(4'd2, 49);
        repeat (8) @(posedge ACLK);
        push_samples(5, 5);
        queue_frame(4'd9, 5, 5);
        send_request(4'd9, 5);
        wait_drain(200);
        check_flag("status", 1'b0, |status);

        test_name = "header_fifo_full";
        ready_mode <= 0;
        push_samples(16, 16);
        for (int f = 0; f < 6; f++) begin
            if (f < 4) begin
                queue_frame(4'(f + 4), 4, 4);
            end
            send_request(4'(f + 4), 4);
        end
        repeat (2) @(posedge ACLK);
        check_flag("req_dropped", 1'b1, status.req_dropped);
        ready_mode <= 1;
        wait_drain(300);
        check_flag("req_dropped after drain", 1'b1, status.req_dropped);

        test_name = "sample_overflow";
        ready_mode <= 0;
        push_samples(70, 64);
        repeat (2) @(posedge ACLK);
        check_flag("sample_dropped", 1'b1, status.sample_dropped);
        queue_frame(4'd7, 48, 48);
        send_request(4'd7, 48);
        queue_frame(4'd8, 16, 16);
        send_request(4'd8, 16);
        ready_mode <= 2;
        wait_drain(600);
        check_flag("sample_dropped after drain", 1'b1, status.sample_dropped);

        test_name = "underflow";
        ready_mode <= 1;
        @(posedge ACLK);
        arst_n <= 1'b0;
        smp_model.delete();
        exp_q.delete();
        seq_model = 0;
        repeat (16) @(posedge ACLK);
        arst_n <= 1'b1;
        repeat (2) @(posedge ACLK);
        push_samples(4, 4);
        queue_frame(4'd5, 10, 4);
        send_request(4'd5, 10);
        wait_drain(200);
        check_flag("underflow", 1'b1, status.underflow);
        push_samples(6, 6);
        queue_frame(4'd2, 6, 6);
        send_request(4'd2, 6);
        wait_drain(200);

        $display("Errors: %0d, beats checked: %0d, frames: %0d", errors, beats_checked,
                 frames_queued);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire
